// ==== logic/storage_pkg.sv ====
`default_nettype none

package storage_pkg;

    // Bus and lane geometry
    localparam int MEM_W = 32;
    localparam int LANES = MEM_W / 8;

    localparam logic [31:0] SRAM_BYTES = 32'h0000_2000; // Also the flash base address
    localparam int SRAM_DEPTH = 2048;                    // Words per byte lane
    localparam int LANE_AW = $clog2(SRAM_DEPTH);

    // SPI flash read transfer
    localparam logic [7:0] FLASH_READ_CMD = 8'h03;
    localparam int FLASH_AW = 24;
    localparam int HDR_BITS = 8 + FLASH_AW;      // Opcode plus address
    localparam int SPI_BITS = HDR_BITS + MEM_W;  // Full transfer length in SCK periods
    localparam int CNT_W = $clog2(SPI_BITS);

    typedef struct packed {
        logic [31:0]      addr;
        logic [MEM_W-1:0] wdata;
        logic [LANES-1:0] be;
        logic             write;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_W-1:0] rdata;
        logic             err;   // Set for writes into the flash region
    } mem_rsp_t;

    // Command for a single byte lane
    typedef struct packed {
        logic               en;
        logic               we;
        logic [LANE_AW-1:0] idx;
        logic [7:0]         data;
    } lane_req_t;

    typedef struct packed {
        logic cs_n;
        logic sck;
        logic mosi;
    } spi_pins_t;

endpackage

`default_nettype wire

// ==== logic/sram_lane.sv ====
`default_nettype none

module sram_lane (
    input  logic                  clk,
    input  storage_pkg::lane_req_t i_req,
    output logic [7:0]            o_rdata
);

    import storage_pkg::*;

    // One byte of every SRAM word
    logic [7:0] mem [SRAM_DEPTH];

    // Write or read on the enabled edge only
    always_ff @(posedge clk) begin
        if (i_req.en) begin
            if (i_req.we) begin
                mem[i_req.idx] <= i_req.data;
            end else begin
                o_rdata <= mem[i_req.idx]; // Valid from the next cycle on
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/spi_flash_reader.sv ====
`default_nettype none

module spi_flash_reader (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_start,
    input  logic [storage_pkg::FLASH_AW-1:0]   i_addr,
    output logic                               o_done,
    output logic [storage_pkg::MEM_W-1:0]      o_rdata,
    output storage_pkg::spi_pins_t             o_spi,
    input  logic                               i_miso
);

    import storage_pkg::*;

    typedef enum logic [1:0] {
        r_idle,
        r_shift,
        r_done
    } rd_state_t;

    rd_state_t         state;
    spi_pins_t         spi_q;
    logic [CNT_W-1:0]  bit_cnt;   // SCK periods completed
    logic              done_q;
    logic [HDR_BITS-1:0] tx_sr;   // Opcode and address, MSB first
    logic [MEM_W-1:0]  rx_sr;
    logic [MEM_W-1:0]  rx_swapped;
    logic [MEM_W-1:0]  rdata_q;

    assign o_spi   = spi_q;
    assign o_done  = done_q;
    assign o_rdata = rdata_q;

    // First byte received sits in the top of rx_sr, it belongs in bits 7:0
    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            rx_swapped[8*b +: 8] = rx_sr[MEM_W-8-8*b +: 8];
        end
    end

    // Pin and sequencing control
    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= r_idle;
            spi_q.cs_n  <= 1'b1;
            spi_q.sck   <= 1'b0;
            spi_q.mosi  <= 1'b0;
            bit_cnt     <= '0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                r_idle: begin
                    if (i_start) begin
                        state      <= r_shift;
                        spi_q.cs_n <= 1'b0;
                        spi_q.sck  <= 1'b0;
                        spi_q.mosi <= FLASH_READ_CMD[7]; // Set up before the first rising edge
                        bit_cnt    <= '0;
                    end
                end
                r_shift: begin
                    spi_q.sck <= ~spi_q.sck; // Half an SCK period per clk
                    if (spi_q.sck) begin
                        // Falling edge, move on to the next bit
                        bit_cnt    <= bit_cnt + 1'b1;
                        spi_q.mosi <= tx_sr[HDR_BITS-2];
                        if (bit_cnt == CNT_W'(SPI_BITS - 1)) begin
                            spi_q.cs_n <= 1'b1;
                            spi_q.mosi <= 1'b0;
                            state      <= r_done;
                        end
                    end
                end
                r_done: begin
                    done_q <= 1'b1; // CS is already high here
                    state  <= r_idle;
                end
                default: begin
                    state <= r_idle;
                end
            endcase
        end
    end

    // Shift registers and result word
    always_ff @(posedge clk) begin
        if (state == r_idle && i_start) begin
            tx_sr <= {FLASH_READ_CMD, i_addr};
        end else if (state == r_shift && spi_q.sck) begin
            tx_sr <= tx_sr << 1; // Zeros follow the address
        end

        // Data bits are sampled as SCK rises
        if (state == r_shift && !spi_q.sck && bit_cnt >= CNT_W'(HDR_BITS)) begin
            rx_sr <= {rx_sr[MEM_W-2:0], i_miso};
        end

        if (state == r_done) begin
            rdata_q <= rx_swapped;
        end
    end

endmodule

`default_nettype wire

// ==== logic/storage_controller.sv ====
`default_nettype none

module storage_controller (
    input  logic                                              clk,
    input  logic                                              rst,

    // Request port
    input  logic                                              i_access,
    input  storage_pkg::mem_req_t                             i_req,
    output logic                                              o_ready,
    output logic                                              o_valid,
    output storage_pkg::mem_rsp_t                             o_rsp,

    // Programming port
    input  logic                                              i_prog_mode,
    input  storage_pkg::spi_pins_t                            i_prog_spi,
    output logic                                              o_prog_miso,

    // Byte lanes
    output storage_pkg::lane_req_t [storage_pkg::LANES-1:0]   o_lane_req,
    input  logic [storage_pkg::LANES-1:0][7:0]                i_lane_rdata,

    // Flash reader
    output logic                                              o_flash_start,
    output logic [storage_pkg::FLASH_AW-1:0]                  o_flash_addr,
    input  logic                                              i_flash_done,
    input  logic [storage_pkg::MEM_W-1:0]                     i_flash_rdata,

    // Flash pins
    input  storage_pkg::spi_pins_t                            i_reader_spi,
    output storage_pkg::spi_pins_t                            o_flash_spi,
    input  logic                                              i_flash_miso
);

    import storage_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_sram,
        s_sram_rsp,
        s_flash,
        s_prog
    } state_t;

    state_t   state;
    state_t   state_nxt;
    mem_req_t req_q;
    logic     is_flash_q;   // Region of the request in flight
    logic     start_q;
    logic     accept;
    logic     flash_hit;

    assign o_ready   = (state == s_idle) && !i_prog_mode;
    assign accept    = i_access && o_ready;
    assign flash_hit = (i_req.addr >= SRAM_BYTES);

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (i_prog_mode) begin
                    state_nxt = s_prog;
                end else if (i_access) begin
                    // Flash writes go the SRAM way, with lanes held off
                    if (flash_hit && !i_req.write) begin
                        state_nxt = s_flash;
                    end else begin
                        state_nxt = s_sram;
                    end
                end
            end
            s_sram:     state_nxt = s_sram_rsp;
            s_sram_rsp: state_nxt = s_idle;
            s_flash: begin
                if (i_flash_done) begin
                    state_nxt = s_idle;
                end
            end
            s_prog: begin
                if (!i_prog_mode) begin
                    state_nxt = s_idle;
                end
            end
            default:    state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= s_idle;
            start_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            start_q <= accept && flash_hit && !i_req.write; // One-cycle reader kick
        end
    end

    // Request capture, region decided here once
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q      <= i_req;
            is_flash_q <= flash_hit;
        end
    end

    assign o_flash_start = start_q;
    assign o_flash_addr  = FLASH_AW'(req_q.addr - SRAM_BYTES);

    // Lane drive, byte enables only matter for writes
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            o_lane_req[l].en   = (state == s_sram) && !is_flash_q
                                 && (!req_q.write || req_q.be[l]);
            o_lane_req[l].we   = req_q.write;
            o_lane_req[l].idx  = req_q.addr[2 +: LANE_AW];
            o_lane_req[l].data = req_q.wdata[8*l +: 8];
        end
    end

    // Response merge
    always_comb begin
        o_valid = 1'b0;
        o_rsp   = '0;
        case (state)
            s_sram_rsp: begin
                o_valid   = 1'b1;
                o_rsp.err = is_flash_q;
                if (!is_flash_q && !req_q.write) begin
                    o_rsp.rdata = i_lane_rdata; // Lane 0 lands in bits 7:0
                end
            end
            s_flash: begin
                o_valid = i_flash_done;
                if (i_flash_done) begin
                    o_rsp.rdata = i_flash_rdata;
                end
            end
            default: begin
                o_valid = 1'b0;
            end
        endcase
    end

    // Programming passthrough
    assign o_flash_spi = (state == s_prog) ? i_prog_spi : i_reader_spi;
    assign o_prog_miso = (state == s_prog) ? i_flash_miso : 1'b0;

endmodule

`default_nettype wire

// ==== logic/storage_top.sv ====
`default_nettype none

module storage_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_access,
    input  storage_pkg::mem_req_t  i_req,
    input  logic                   i_prog_mode,
    input  logic                   i_flash_miso,
    input  storage_pkg::spi_pins_t i_prog_spi,
    output logic                   o_ready,
    output logic                   o_valid,
    output storage_pkg::mem_rsp_t  o_rsp,
    output storage_pkg::spi_pins_t o_flash_spi,
    output logic                   o_prog_miso
);

    import storage_pkg::*;

    lane_req_t [LANES-1:0]       lane_req;
    logic      [LANES-1:0][7:0]  lane_rdata;
    logic                        flash_start;
    logic      [FLASH_AW-1:0]    flash_addr;
    logic                        flash_done;
    logic      [MEM_W-1:0]       flash_rdata;
    spi_pins_t                   reader_spi;

    storage_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_access      (i_access),
        .i_req         (i_req),
        .o_ready       (o_ready),
        .o_valid       (o_valid),
        .o_rsp         (o_rsp),
        .i_prog_mode   (i_prog_mode),
        .i_prog_spi    (i_prog_spi),
        .o_prog_miso   (o_prog_miso),
        .o_lane_req    (lane_req),
        .i_lane_rdata  (lane_rdata),
        .o_flash_start (flash_start),
        .o_flash_addr  (flash_addr),
        .i_flash_done  (flash_done),
        .i_flash_rdata (flash_rdata),
        .i_reader_spi  (reader_spi),
        .o_flash_spi   (o_flash_spi),
        .i_flash_miso  (i_flash_miso)
    );

    // One lane per byte of the data bus
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        sram_lane u_lane (
            .clk     (clk),
            .i_req   (lane_req[g]),
            .o_rdata (lane_rdata[g])
        );
    end

    spi_flash_reader u_reader (
        .clk     (clk),
        .rst     (rst),
        .i_start (flash_start),
        .i_addr  (flash_addr),
        .o_done  (flash_done),
        .o_rdata (flash_rdata),
        .o_spi   (reader_spi),
        .i_miso  (i_flash_miso)   // Shared with the passthrough path
    );

endmodule

`default_nettype wire

// ==== tb/spi_flash_model.sv ====
`default_nettype none

module spi_flash_model (
    input  storage_pkg::spi_pins_t i_spi,
    output logic                   o_miso
);

    import storage_pkg::*;

    logic [31:0] hdr = '0;   // Opcode then address, MSB first
    int          rises = 0;  // Rising SCK edges since CS fell
    logic [23:0] byte_addr;
    logic [7:0]  pattern;
    int          pos;

    initial o_miso = 1'b0;

    always @(posedge i_spi.sck or posedge i_spi.cs_n) begin
        if (i_spi.cs_n) begin
            rises <= 0;
        end else begin
            if (rises < 32) hdr <= {hdr[30:0], i_spi.mosi};
            rises <= rises + 1;
        end
    end

    // Read data leaves MSB first on falling edges, bytes at rising addresses
    always @(negedge i_spi.sck) begin
        if (!i_spi.cs_n && rises >= 32 && rises < 64 && hdr[31:24] == FLASH_READ_CMD) begin
            pos       = rises - 32;
            byte_addr = hdr[23:0] + 24'(pos / 8);
            pattern   = byte_addr[7:0] ^ 8'hA5;   // Fixed content of every flash byte
            o_miso   <= pattern[7 - pos % 8];
        end
    end

endmodule

`default_nettype wire

// ==== tb/storage_assertions.sv ====
`default_nettype none

module storage_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   i_access,
    input logic                   i_prog_mode,
    input logic                   o_ready,
    input logic                   o_valid,
    input storage_pkg::spi_pins_t i_prog_spi,
    input storage_pkg::spi_pins_t o_flash_spi
);

    logic in_flight;   // Between an accept and its response
    logic in_prog;     // Programming passthrough active

    always @(posedge clk) begin
        if (!rst) begin
            in_flight <= 1'b0;
            in_prog   <= 1'b0;
        end else begin
            in_prog <= i_prog_mode && !in_flight; // Entered only from idle
            if (o_valid) begin
                in_flight <= 1'b0;
            end else if (i_access && o_ready) begin
                in_flight <= 1'b1;
            end
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst) o_valid |=> !o_valid)
        else $error("o_valid high on two cycles in a row");

    a_prog_cs: assert property (@(posedge clk) disable iff (!rst)
        in_prog |-> o_flash_spi.cs_n == i_prog_spi.cs_n)
        else $error("flash cs_n does not follow the programming port");

    a_busy: assert property (@(posedge clk) disable iff (!rst) in_flight |-> !o_ready)
        else $error("o_ready high while a request is in flight");

endmodule

bind storage_top storage_assertions u_assert (
    .clk         (clk),
    .rst         (rst),
    .i_access    (i_access),
    .i_prog_mode (i_prog_mode),
    .o_ready     (o_ready),
    .o_valid     (o_valid),
    .i_prog_spi  (i_prog_spi),
    .o_flash_spi (o_flash_spi)
);

`default_nettype wire

// ==== tb/storage_tb.sv ====
`default_nettype none

module storage_tb;

    import storage_pkg::*;

    localparam int        TIMEOUT   = 400;  // Cycles allowed per wait
    localparam spi_pins_t IDLE_PINS = '{cs_n: 1'b1, sck: 1'b0, mosi: 1'b0};

    logic               clk = 1'b0;
    logic               rst;
    logic               i_access;
    logic               i_prog_mode;
    mem_req_t           i_req;
    spi_pins_t          i_prog_spi;
    logic               o_ready;
    logic               o_valid;
    logic               o_prog_miso;
    mem_rsp_t           o_rsp;
    spi_pins_t          o_flash_spi;
    logic               model_miso;
    logic               prog_miso;    // Flash MISO while the programming port owns the pins
    int                 seed;
    logic [31:0]        r;
    logic [LANE_AW-1:0] idx;
    logic [7:0]         sram_model [SRAM_DEPTH][LANES];
    logic [LANE_AW-1:0] written [$];  // Words holding known data

    always #2 clk = ~clk;

    storage_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_access     (i_access),
        .i_req        (i_req),
        .i_prog_mode  (i_prog_mode),
        .i_flash_miso (i_prog_mode ? prog_miso : model_miso),
        .i_prog_spi   (i_prog_spi),
        .o_ready      (o_ready),
        .o_valid      (o_valid),
        .o_rsp        (o_rsp),
        .o_flash_spi  (o_flash_spi),
        .o_prog_miso  (o_prog_miso)
    );

    spi_flash_model u_flash (
        .i_spi  (o_flash_spi),
        .o_miso (model_miso)
    );

    task automatic report_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH o_rsp: rdata=%h err=%h, expected rdata=%h err=%h",
                got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_spi(input spi_pins_t got, input spi_pins_t exp);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH o_flash_spi: got %h, expected %h", got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            report_error($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic [LANE_AW-1:0] pick_written();
        logic [31:0] k;
        k = $random(seed);
        return written[k % written.size()];
    endfunction

    // Controller idle and able to take a request
    task automatic wait_ready();
        int n;
        n = 0;
        while (o_ready !== 1'b1) begin
            if (n >= TIMEOUT) report_error("timed out waiting for o_ready");
            @(negedge clk);
            n++;
        end
    endtask

    // One request through the port, returns the response and its latency
    task automatic do_access(input mem_req_t req, input logic watch_pins,
                             output mem_rsp_t rsp, output int lat);
        wait_ready();
        i_req    = req;
        i_access = 1'b1;
        @(negedge clk);   // Accept edge just passed
        i_access = 1'b0;
        lat      = 1;
        while (o_valid !== 1'b1) begin
            if (watch_pins) check_spi(o_flash_spi, IDLE_PINS);
            if (lat >= TIMEOUT) report_error("timed out waiting for o_valid");
            @(negedge clk);
            lat++;
        end
        if (watch_pins) check_spi(o_flash_spi, IDLE_PINS);
        rsp = o_rsp;
        if (!(req.addr >= SRAM_BYTES && !req.write) && lat != 2) begin
            report_error($sformatf("o_valid came %0d cycles after the accept, not 2", lat));
        end
    endtask

    task automatic sram_access(input logic [LANE_AW-1:0] w, input logic write,
                               input logic [31:0] data, input logic [LANES-1:0] be);
        mem_rsp_t rsp;
        mem_rsp_t exp;
        int       lat;
        exp = '0;
        do_access('{addr: 32'({w, 2'b00}), wdata: data, be: be, write: write}, 1'b0, rsp, lat);
        for (int l = 0; l < LANES; l++) begin
            if (write && be[l]) sram_model[w][l] = data[8*l +: 8];
            if (!write) exp.rdata[8*l +: 8] = sram_model[w][l];
        end
        check_rsp(rsp, exp);
    endtask

    task automatic flash_access(input logic [31:0] addr, input logic write);
        mem_rsp_t    rsp;
        mem_rsp_t    exp;
        logic [23:0] fa;
        int          lat;
        fa  = 24'(addr - SRAM_BYTES);
        exp = '0;
        exp.err = write;   // Flash region is read only
        for (int i = 0; i < LANES; i++) begin
            if (!write) exp.rdata[8*i +: 8] = (fa[7:0] + 8'(i)) ^ 8'hA5;
        end
        do_access('{addr: addr, wdata: $random(seed), be: 4'hF, write: write}, write, rsp, lat);
        check_rsp(rsp, exp);
    endtask

    initial begin
        seed        = 76;
        rst         = 1'b0;
        i_access    = 1'b0;
        i_req       = '0;
        i_prog_mode = 1'b0;
        i_prog_spi  = IDLE_PINS;
        prog_miso   = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        check_bit(o_ready, 1'b1, "o_ready");
        check_bit(o_valid, 1'b0, "o_valid");
        check_spi(o_flash_spi, IDLE_PINS);

        repeat (48) begin
            r = $random(seed);
            sram_access(r[LANE_AW-1:0], 1'b1, $random(seed), 4'hF);
            written.push_back(r[LANE_AW-1:0]);
        end
        repeat (48) sram_access(pick_written(), 1'b0, '0, '0);

        // Partial writes, read back at once
        repeat (48) begin
            idx = pick_written();
            r   = $random(seed);
            sram_access(idx, 1'b1, $random(seed), r[LANES-1:0]);
            sram_access(idx, 1'b0, '0, '0);
        end

        flash_access(SRAM_BYTES, 1'b0);
        repeat (8) begin
            r = $random(seed);
            if (r < SRAM_BYTES) r = r + SRAM_BYTES;
            flash_access(r, 1'b0);
        end
        repeat (4) flash_access(SRAM_BYTES + ($random(seed) & 32'hFFFF), 1'b1);

        // Programming passthrough
        wait_ready();
        i_prog_mode = 1'b1;
        @(negedge clk);
        repeat (32) begin
            r          = $random(seed);
            i_prog_spi = r[2:0];
            prog_miso  = r[3];
            @(negedge clk);
            check_spi(o_flash_spi, i_prog_spi);
            check_bit(o_prog_miso, prog_miso, "o_prog_miso");
            check_bit(o_ready, 1'b0, "o_ready");
        end
        i_prog_spi  = IDLE_PINS;
        i_prog_mode = 1'b0;
        @(negedge clk);
        check_bit(o_prog_miso, 1'b0, "o_prog_miso");
        check_bit(o_ready, 1'b1, "o_ready");
        repeat (16) sram_access(pick_written(), 1'b0, '0, '0);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== storage.f ====
logic/storage_pkg.sv
logic/sram_lane.sv
logic/spi_flash_reader.sv
logic/storage_controller.sv
logic/storage_top.sv
tb/spi_flash_model.sv
tb/storage_assertions.sv
tb/storage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the storage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module storage_tb \
    -f storage.f -Mdir obj_dir -o storage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/storage_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
